// ==== baud_gen.sv ====
// Baud timebase
// Free-running divider, one-cycle tick every UART_BAUD_DIV clocks
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module baud_gen import uart_types_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  output logic tick_o   // Bit period strobe
);

  localparam baud_cnt_t CNT_LAST = baud_cnt_t'(`UART_BAUD_DIV - 1);

  baud_cnt_t cnt_q;
  logic      wrap;

  assign wrap = (cnt_q == CNT_LAST);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tick_o = wrap; // High on the last count only

  // A divisor of at least two keeps ticks apart
  a_tick_single : assert property (
    @(posedge clk_i) disable iff (rst_i) tick_o |=> !tick_o
  );

endmodule

// ==== tb_uart_tx.sv ====
// Testbench for the UART transmit subsystem
// Replays frames from the pattern file, decodes the serial line and
// checks data order, parity, stop level, idle and FIFO full behavior
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module tb_uart_tx import uart_types_pkg::*; ();

  localparam int HALF_PERIOD  = 10;                      // 20 ns clock
  localparam int START_LIMIT  = 4 * `UART_BAUD_DIV;      // Cycles to see a start bit
  localparam int IDLE_LIMIT   = 16 * `UART_BAUD_DIV;     // Cycles to return to idle
  localparam int BURST_LEN    = 5;
  localparam int OVER_LEN     = `UART_FIFO_DEPTH + 2;    // One beyond what fits

  logic       clk_i;
  logic       rst_i;
  logic       wr_i;
  uart_byte_t data_i;
  logic       psel_i;
  logic       tx_o;
  logic       full_o;
  logic       idle_o;

  logic [31:0] lfsr_q = 32'd87687;

  uart_tx_top u_uart_tx_top (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .wr_i   (wr_i),
    .data_i (data_i),
    .psel_i (psel_i),
    .tx_o   (tx_o),
    .full_o (full_o),
    .idle_o (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [7:0] lfsr_bits(input int n);
    logic [7:0] v;
    logic       fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[6:0], fb};
    end
    return v;
  endfunction

  // Starts and ends on a falling edge
  task automatic write_byte(input uart_byte_t b);
    wr_i   = 1'b1;
    data_i = b;
    @(negedge clk_i);
    wr_i   = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (idle_o !== 1'b1) begin
      if (n >= IDLE_LIMIT) report_timeout("idle_o to return high");
      n++;
      @(negedge clk_i);
    end
  endtask

  // Receive one frame with samples near each bit midpoint
  task automatic decode_frame(input logic par_en, input logic last,
                              output uart_byte_t data, output logic par_bit);
    int n;
    n       = 0;
    data    = '0;
    par_bit = 1'b0;
    @(negedge clk_i);
    while (tx_o !== 1'b0) begin
      if (n >= START_LIMIT) report_timeout("a start bit on tx_o");
      n++;
      @(negedge clk_i);
    end
    repeat (`UART_BAUD_DIV / 2 - 1) @(negedge clk_i); // Half a cycle already gone
    check("tx_o start bit", tx_o, 1'b0);
    check("idle_o in frame", idle_o, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (`UART_BAUD_DIV) @(negedge clk_i);
      data[i] = tx_o;                                  // LSB first
      check("idle_o in frame", idle_o, 1'b0);
    end
    if (par_en) begin
      repeat (`UART_BAUD_DIV) @(negedge clk_i);
      par_bit = tx_o;
      check("idle_o in frame", idle_o, 1'b0);
    end
    repeat (`UART_BAUD_DIV) @(negedge clk_i);
    check("tx_o stop bit", tx_o, 1'b1);
    check("idle_o at stop bit", idle_o, last);          // Low while more bytes wait
  endtask

  task automatic run_pattern(input logic pen, input uart_byte_t b, input logic exp_par);
    uart_byte_t got;
    logic       par;
    wait_idle();
    psel_i = pen;
    write_byte(b);
    decode_frame(pen, 1'b1, got, par);
    check("tx_o data byte", got, b);
    if (pen) check("tx_o parity bit", par, exp_par);
    wait_idle();
  endtask

  // Back to back bytes with random gaps
  task automatic run_burst();
    uart_byte_t bytes [BURST_LEN];
    uart_byte_t got;
    logic [7:0] gap;
    logic       par;
    for (int i = 0; i < BURST_LEN; i++) bytes[i] = lfsr_bits(8);
    wait_idle();
    psel_i = 1'b0;
    fork
      begin
        for (int i = 0; i < BURST_LEN; i++) begin
          gap = lfsr_bits(3);
          repeat (gap) @(negedge clk_i);
          write_byte(bytes[i]);
        end
      end
      begin
        for (int i = 0; i < BURST_LEN; i++) begin
          decode_frame(1'b0, i == BURST_LEN - 1, got, par);
          check("tx_o burst byte", got, bytes[i]);
        end
      end
    join
    wait_idle();
  endtask

  // Overfill the FIFO while the first frame is on the line
  task automatic run_overflow();
    uart_byte_t bytes [OVER_LEN];
    uart_byte_t got;
    logic       par;
    for (int i = 0; i < OVER_LEN; i++) bytes[i] = lfsr_bits(8);
    wait_idle();
    psel_i = 1'b0;
    fork
      begin
        for (int i = 0; i < OVER_LEN; i++) write_byte(bytes[i]);
        check("full_o", full_o, 1'b1);
      end
      begin
        // Depth plus one bytes get through and the last write is dropped
        for (int i = 0; i < OVER_LEN - 1; i++) begin
          decode_frame(1'b0, i == OVER_LEN - 2, got, par);
          check("tx_o overflow byte", got, bytes[i]);
        end
      end
    join
    wait_idle();
    check("full_o", full_o, 1'b0);
    for (int i = 0; i < 4 * `UART_BAUD_DIV; i++) begin
      @(negedge clk_i);
      check("tx_o after last frame", tx_o, 1'b1);
    end
  endtask

  initial begin
    int         fd;
    int         rc;
    int         count;
    string      line;
    logic [7:0] pen_v;
    logic [7:0] byte_v;
    logic [7:0] par_v;
    rst_i  = 1'b1;
    wr_i   = 1'b0;
    data_i = '0;
    psel_i = 1'b0;
    count  = 0;
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check("tx_o", tx_o, 1'b1);
    check("idle_o", idle_o, 1'b1);
    check("full_o", full_o, 1'b0);

    fd = $fopen("uart_tx_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      $display("STATUS: FAIL");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 0 && line[0] != "#") begin
        rc = $sscanf(line, "%h %h %h", pen_v, byte_v, par_v);
        if (rc == 3) begin
          run_pattern(pen_v[0], byte_v, par_v[0]);
          count++;
        end
      end
    end
    $fclose(fd);
    if (count == 0) begin
      $display("No frames were read from the pattern file");
      $display("STATUS: FAIL");
      $fatal(1);
    end

    run_burst();
    run_overflow();
    wait_idle();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== tx_fifo.sv ====
// Transmit FIFO
// Register-array buffer between the host writes and the transmitter
// with the head visible on rd_data_o while not empty
`timescale 1ns/1ps
`include "uart_tx_macros.svh"

module tx_fifo import uart_types_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       wr_i,       // Host write strobe
  input  uart_byte_t data_i,
  input  logic       pop_i,      // Transmitter takes the head
  output uart_byte_t rd_data_o,  // Head of queue
  output logic       empty_o,
  output logic       full_o
);

  uart_byte_t mem [`UART_FIFO_DEPTH];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;

  logic [`UART_FIFO_AW-1:0] wr_addr;
  logic [`UART_FIFO_AW-1:0] rd_addr;
  logic                     do_wr;
  logic                     do_rd;

  assign wr_addr = wr_ptr_q[`UART_FIFO_AW-1:0];
  assign rd_addr = rd_ptr_q[`UART_FIFO_AW-1:0];

  // Wrap bits tell full from empty at the same address
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[`UART_FIFO_AW] != rd_ptr_q[`UART_FIFO_AW]) &&
                   (wr_addr == rd_addr);

  assign do_wr = wr_i && !full_o;   // Write while full is dropped
  assign do_rd = pop_i && !empty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_addr] <= data_i;
    end
  end

  // Pointers
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= fifo_ptr_t'(wr_ptr_q + 1'b1);
      end
      if (do_rd) begin
        rd_ptr_q <= fifo_ptr_t'(rd_ptr_q + 1'b1);
      end
    end
  end

  assign rd_data_o = mem[rd_addr]; // First word fall through

  // The transmitter only pops a byte it has seen
  a_no_pop_empty : assert property (
    @(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o
  );

  // Occupancy never goes past the depth
  a_occupancy : assert property (
    @(posedge clk_i) disable iff (rst_i)
      fifo_ptr_t'(wr_ptr_q - rd_ptr_q) <= fifo_ptr_t'(`UART_FIFO_DEPTH)
  );

endmodule

// ==== tx_frame_mux.sv ====
// Transmit frame mux
// Holds the byte being sent, forms even parity and registers the line
`timescale 1ns/1ps

module tx_frame_mux
  import uart_types_pkg::*;
  import uart_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       pop_i,   // Capture the FIFO head
  input  uart_byte_t data_i,
  input  bit_sel_t   sel_i,
  output logic       tx_o     // Serial line
);

  uart_byte_t byte_q;
  logic       parity;
  logic [2:0] bit_idx;
  logic       tx_d;

  always_ff @(posedge clk_i) begin
    if (pop_i) begin
      byte_q <= data_i;
    end
  end

  assign parity  = ^byte_q;              // Even parity
  assign bit_idx = 3'(sel_i - SEL_D0);   // Data bit number

  always_comb begin
    case (sel_i)
      SEL_IDLE:   tx_d = 1'b1;
      SEL_START:  tx_d = 1'b0;
      SEL_PARITY: tx_d = parity;
      default:    tx_d = byte_q[bit_idx];  // D0..D7, LSB first
    endcase
  end

  // One cycle behind the select for every bit
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tx_o <= 1'b1;
    end else begin
      tx_o <= tx_d;
    end
  end

endmodule

// ==== tx_fsm.sv ====
// Transmit frame FSM
// Walks start, eight data bits and optional parity, one state per tick,
// and tells the frame mux which element to drive
`timescale 1ns/1ps

module tx_fsm import uart_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     empty_i,  // FIFO has nothing to send
  input  logic     tick_i,   // Bit period strobe
  input  logic     psel_i,   // Parity enable
  output bit_sel_t sel_o,    // Frame element select
  output logic     pop_o,    // Take the head byte
  output logic     idle_o    // Nothing in flight, nothing queued
);

  tx_state_t state_q;
  tx_state_t state_d;
  logic      eot;            // End of transmission
  logic      st;             // Start condition

  assign eot    = (state_q == ST_IDLE);
  assign st     = eot && !empty_i;
  assign pop_o  = st;        // Leaves idle on this edge
  assign idle_o = eot && empty_i;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (st) state_d = ST_SYNC;
      end
      ST_SYNC: begin
        if (tick_i) state_d = ST_START;
      end
      ST_START: begin
        if (tick_i) state_d = ST_D0;
      end
      ST_D0: if (tick_i) state_d = ST_D1;
      ST_D1: if (tick_i) state_d = ST_D2;
      ST_D2: if (tick_i) state_d = ST_D3;
      ST_D3: if (tick_i) state_d = ST_D4;
      ST_D4: if (tick_i) state_d = ST_D5;
      ST_D5: if (tick_i) state_d = ST_D6;
      ST_D6: if (tick_i) state_d = ST_D7;
      ST_D7: begin
        if (tick_i) begin
          state_d = psel_i ? ST_PARITY : ST_IDLE;
        end
      end
      ST_PARITY: begin
        if (tick_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Select decode
  always_comb begin
    case (state_q)
      ST_START:  sel_o = SEL_START;
      ST_D0:     sel_o = SEL_D0;
      ST_D1:     sel_o = SEL_D0 + 4'd1;
      ST_D2:     sel_o = SEL_D0 + 4'd2;
      ST_D3:     sel_o = SEL_D0 + 4'd3;
      ST_D4:     sel_o = SEL_D0 + 4'd4;
      ST_D5:     sel_o = SEL_D0 + 4'd5;
      ST_D6:     sel_o = SEL_D0 + 4'd6;
      ST_D7:     sel_o = SEL_D0 + 4'd7;
      ST_PARITY: sel_o = SEL_PARITY;
      default:   sel_o = SEL_IDLE;   // Idle and sync hold the line high
    endcase
  end

  // State register
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Parity choice at D7 needs psel_i held through the whole frame
  a_psel_stable : assert property (
    @(posedge clk_i) disable iff (rst_i) !eot |-> $stable(psel_i)
  );

endmodule

// ==== uart_ctrl_pkg.sv ====
// UART transmit control types
// Frame state encoding and the frame mux select with its fixed codes
package uart_ctrl_pkg;

  typedef enum logic [3:0] {
    ST_IDLE   = 4'd0,  // Wait, line high, doubles as stop bit
    ST_SYNC   = 4'd1,  // Align to the next tick
    ST_START  = 4'd2,
    ST_D0     = 4'd3,
    ST_D1     = 4'd4,
    ST_D2     = 4'd5,
    ST_D3     = 4'd6,
    ST_D4     = 4'd7,
    ST_D5     = 4'd8,
    ST_D6     = 4'd9,
    ST_D7     = 4'd10,
    ST_PARITY = 4'd11
  } tx_state_t;

  // Which frame element the mux puts on the line
  typedef logic [3:0] bit_sel_t;

  localparam bit_sel_t SEL_IDLE   = 4'd0;  // Idle or stop, line high
  localparam bit_sel_t SEL_START  = 4'd1;
  localparam bit_sel_t SEL_D0     = 4'd2;  // D0..D7 follow as 2..9
  localparam bit_sel_t SEL_PARITY = 4'd10;

endpackage

// ==== uart_tx.f ====
+incdir+.
uart_types_pkg.sv
uart_ctrl_pkg.sv
baud_gen.sv
tx_fifo.sv
tx_fsm.sv
tx_frame_mux.sv
uart_tx_top.sv
tb_uart_tx.sv

// ==== uart_tx_macros.svh ====
// UART transmitter constants
// Sizes for the host FIFO and the baud timebase
`ifndef UART_TX_MACROS_SVH
`define UART_TX_MACROS_SVH

// Host side buffer
`define UART_FIFO_DEPTH 8 // Entries
`define UART_FIFO_AW    3 // Address bits, log2 of depth

// Timebase
`define UART_BAUD_DIV   16 // Clocks per bit, short for simulation
`define UART_BAUD_CW    4  // Must hold UART_BAUD_DIV-1

`endif

// ==== uart_tx_patterns.txt ====
# Columns (hex): parity enable, data byte, expected parity bit
# Parity bit is the even parity of the byte, checked only when parity is enabled
0 55 0
0 a3 0
0 01 1
0 fe 1
1 00 0
1 80 1
1 5a 0
1 c7 1
1 ff 0

// ==== uart_tx_top.sv ====
// UART transmit subsystem
// Host FIFO, baud timebase, frame FSM and frame mux
`timescale 1ns/1ps

module uart_tx_top
  import uart_types_pkg::*;
  import uart_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       wr_i,     // Host write strobe
  input  uart_byte_t data_i,
  input  logic       psel_i,   // Parity enable, change only while idle
  output logic       tx_o,
  output logic       full_o,
  output logic       idle_o
);

  uart_byte_t rd_data;
  logic       empty;
  logic       pop;
  logic       tick;
  bit_sel_t   sel;

  tx_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_i      (wr_i),
    .data_i    (data_i),
    .pop_i     (pop),
    .rd_data_o (rd_data),
    .empty_o   (empty),
    .full_o    (full_o)
  );

  baud_gen u_baud (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tick_o (tick)
  );

  tx_fsm u_fsm (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .empty_i (empty),
    .tick_i  (tick),
    .psel_i  (psel_i),
    .sel_o   (sel),
    .pop_o   (pop),
    .idle_o  (idle_o)
  );

  tx_frame_mux u_mux (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .pop_i  (pop),
    .data_i (rd_data),
    .sel_i  (sel),
    .tx_o   (tx_o)
  );

endmodule

// ==== uart_types_pkg.sv ====
// UART data types
// Widths for the data path, the FIFO pointers and the baud counter
`include "uart_tx_macros.svh"

package uart_types_pkg;

  // One character on the line
  typedef logic [7:0] uart_byte_t;

  // Extra MSB is the wrap bit, tells full from empty
  typedef logic [`UART_FIFO_AW:0] fifo_ptr_t;

  typedef logic [`UART_BAUD_CW-1:0] baud_cnt_t; // Timebase divider count

endpackage
